//--- source/mul_defines.svh
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

////////////////////
// widths
////////////////////

// operand width of the integer datapath
`define MUL_DATA_LEN 32

// full product, kept at double width
`define MUL_PROD_LEN (2 * `MUL_DATA_LEN)

// reorder buffer tag
`define MUL_ROB_ID_W 6

`define MUL_FUNC3_W 3

////////////////////
// function codes
////////////////////

// signed x signed
`define MUL_FUNC3_MUL    3'b000
`define MUL_FUNC3_MULH   3'b001
// signed x unsigned
`define MUL_FUNC3_MULHSU 3'b010
// unsigned x unsigned
`define MUL_FUNC3_MULHU  3'b011

`endif

//--- source/mul_pkg.sv
`include "mul_defines.svh"

package mul_pkg;

    ////////////////////
    // datapath vectors
    ////////////////////

    // one source operand
    typedef logic [`MUL_DATA_LEN-1:0] data_t;

    // one partial-product row, tree row or final product
    typedef logic [`MUL_PROD_LEN-1:0] prod_t;

    ////////////////////
    // control vectors
    ////////////////////

    // tag carried alongside the operation
    typedef logic [`MUL_ROB_ID_W-1:0] rob_id_t;

    // selects signedness of both operands
    typedef logic [`MUL_FUNC3_W-1:0] func3_t;

endpackage

//--- source/mul_pp_gen.sv
`include "mul_defines.svh"

module mul_pp_gen import mul_pkg::*; (
    input  data_t                          op1_i,
    input  data_t                          op2_i,
    input  func3_t                         func3_i,
    output prod_t [`MUL_DATA_LEN-1:0]      pp_o
);

    localparam int LAST = `MUL_DATA_LEN - 1;

    logic  signed_op1;
    logic  signed_op2;
    prod_t op1_ext;
    prod_t op1_neg;
    prod_t last_mcand;

    ////////////////////
    // signedness decode
    ////////////////////

    always_comb begin
        case (func3_i)
            `MUL_FUNC3_MUL: begin
                signed_op1 = 1'b1;
                signed_op2 = 1'b1;
            end
            `MUL_FUNC3_MULH: begin
                signed_op1 = 1'b1;
                signed_op2 = 1'b1;
            end
            `MUL_FUNC3_MULHSU: begin
                signed_op1 = 1'b1;
                signed_op2 = 1'b0;
            end
            `MUL_FUNC3_MULHU: begin
                signed_op1 = 1'b0;
                signed_op2 = 1'b0;
            end
            // unknown codes fall back to plain mul
            default: begin
                signed_op1 = 1'b1;
                signed_op2 = 1'b1;
            end
        endcase
    end

    ////////////////////
    // multiplicand forms
    ////////////////////

    // operand one widened to the product width
    always_comb begin
        if (signed_op1) begin
            op1_ext = {{`MUL_DATA_LEN{op1_i[LAST]}}, op1_i};
        end else begin
            op1_ext = {{`MUL_DATA_LEN{1'b0}}, op1_i};
        end
    end

    // negated at full width, so the most negative operand stays exact
    assign op1_neg = ~op1_ext + 1'b1;

    // msb of a signed operand two has weight -2^31
    assign last_mcand = signed_op2 ? op1_neg : op1_ext;

    ////////////////////
    // partial products
    ////////////////////

    always_comb begin
        for (int i = 0; i < LAST; i++) begin
            if (op2_i[i]) begin
                pp_o[i] = op1_ext << i;
            end else begin
                pp_o[i] = '0;
            end
        end

        // last row, extended to the full product width
        if (op2_i[LAST]) begin
            pp_o[LAST] = last_mcand << LAST;
        end else begin
            pp_o[LAST] = '0;
        end
    end

endmodule

//--- source/compressor_4to2.sv
module compressor_4to2 (
    input  logic in1_i,
    input  logic in2_i,
    input  logic in3_i,
    input  logic in4_i,
    input  logic cin_i,
    output logic sum_o,
    output logic carry_o,
    output logic cout_o
);

    logic fa1_sum;

    // first full adder on three of the inputs
    // its carry goes sideways and never sees cin_i
    assign fa1_sum = in1_i ^ in2_i ^ in3_i;
    assign cout_o  = (in1_i & in2_i) | (in1_i & in3_i) | (in2_i & in3_i);

    // second full adder folds in the fourth bit and the lateral carry
    assign sum_o   = fa1_sum ^ in4_i ^ cin_i;
    assign carry_o = (fa1_sum & in4_i) | (fa1_sum & cin_i) | (in4_i & cin_i);

endmodule

//--- source/compressor_stage.sv
`include "mul_defines.svh"

module compressor_stage import mul_pkg::*; #(
    // multiple of 4
    parameter int ROWS_IN = 32
) (
    input  prod_t [ROWS_IN-1:0]   rows_i,
    output prod_t [ROWS_IN/2-1:0] rows_o
);

    localparam int GROUPS = ROWS_IN / 4;
    localparam int W      = `MUL_PROD_LEN;

    ////////////////////
    // 4:2 chains
    ////////////////////

    // one chain per group of four rows, one cell per bit position
    for (genvar g = 0; g < GROUPS; g++) begin : g_group
        prod_t sum_row;
        prod_t carry_row;
        prod_t lat_cout;
        prod_t lat_cin;

        // lateral carries move one bit left, chain starts at zero
        // the top cout has weight 2^64 and drops out
        assign lat_cin = {lat_cout[W-2:0], 1'b0};

        for (genvar b = 0; b < W; b++) begin : g_bit
            compressor_4to2 u_cell (
                .in1_i   (rows_i[4*g][b]),
                .in2_i   (rows_i[4*g+1][b]),
                .in3_i   (rows_i[4*g+2][b]),
                .in4_i   (rows_i[4*g+3][b]),
                .cin_i   (lat_cin[b]),
                .sum_o   (sum_row[b]),
                .carry_o (carry_row[b]),
                .cout_o  (lat_cout[b])
            );
        end

        ////////////////////
        // output rows
        ////////////////////

        assign rows_o[2*g] = sum_row;

        // carry of bit b weighs 2^(b+1), top bit falls off modulo 2^64
        assign rows_o[2*g+1] = {carry_row[W-2:0], 1'b0};
    end

endmodule

//--- source/int_mul.sv
`include "mul_defines.svh"

module int_mul import mul_pkg::*; (
    input  logic    clk,
    input  logic    arst_n_i,
    input  logic    mul_val_i,
    input  data_t   op1_i,
    input  data_t   op2_i,
    input  func3_t  func3_i,
    input  rob_id_t robid_i,
    output logic    mul_val_o,
    output prod_t   mul_result_o,
    output rob_id_t robid_o
);

    localparam int ROWS0 = `MUL_DATA_LEN;
    localparam int ROWS1 = ROWS0 / 2;
    localparam int ROWS2 = ROWS1 / 2;
    localparam int ROWS3 = ROWS2 / 2;
    localparam int ROWS4 = ROWS3 / 2;

    prod_t [ROWS0-1:0] pp;
    prod_t [ROWS1-1:0] tree_l1;
    prod_t [ROWS2-1:0] tree_l2;
    prod_t [ROWS3-1:0] tree_l3;
    prod_t [ROWS4-1:0] tree_l4;

    prod_t sum_q;
    prod_t carry_q;

    ////////////////////
    // stage 1
    ////////////////////

    mul_pp_gen u_pp_gen (
        .op1_i   (op1_i),
        .op2_i   (op2_i),
        .func3_i (func3_i),
        .pp_o    (pp)
    );

    // 32 -> 16 -> 8 -> 4 -> 2
    compressor_stage #(.ROWS_IN(ROWS0)) u_tree_l1 (
        .rows_i (pp),
        .rows_o (tree_l1)
    );

    compressor_stage #(.ROWS_IN(ROWS1)) u_tree_l2 (
        .rows_i (tree_l1),
        .rows_o (tree_l2)
    );

    compressor_stage #(.ROWS_IN(ROWS2)) u_tree_l3 (
        .rows_i (tree_l2),
        .rows_o (tree_l3)
    );

    compressor_stage #(.ROWS_IN(ROWS3)) u_tree_l4 (
        .rows_i (tree_l3),
        .rows_o (tree_l4)
    );

    ////////////////////
    // stage boundary
    ////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mul_val_o <= 1'b0;
        end else begin
            mul_val_o <= mul_val_i;
        end
    end

    // payload is only meaningful while mul_val_o is high
    always_ff @(posedge clk) begin
        sum_q   <= tree_l4[0];
        carry_q <= tree_l4[1];
        robid_o <= robid_i;
    end

    ////////////////////
    // stage 2
    ////////////////////

    // carry-propagate add of the redundant pair
    assign mul_result_o = sum_q + carry_q;

endmodule

//--- verification/int_mul_tb_cases.svh
// directed cases for the multiplier
// columns: function code, operand one, operand two, expected 64-bit product, name

localparam int NUM_CASES = 18;

func3_t case_func3 [NUM_CASES];
data_t  case_op1   [NUM_CASES];
data_t  case_op2   [NUM_CASES];
prod_t  case_exp   [NUM_CASES];
string  case_name  [NUM_CASES];

task automatic set_case(
    input int     idx,
    input func3_t f,
    input data_t  a,
    input data_t  b,
    input prod_t  p,
    input string  name
);
    case_func3[idx] = f;
    case_op1[idx]   = a;
    case_op2[idx]   = b;
    case_exp[idx]   = p;
    case_name[idx]  = name;
endtask

task automatic load_cases();
    // signed x signed
    set_case(0, `MUL_FUNC3_MUL, 32'h0000_0003, 32'h0000_0005, 64'h0000_0000_0000_000F, "mul 3x5");
    set_case(1, `MUL_FUNC3_MUL, 32'hFFFF_FFFE, 32'h0000_0003, 64'hFFFF_FFFF_FFFF_FFFA, "mul -2x3");
    set_case(2, `MUL_FUNC3_MUL, 32'hFFFF_FFF9, 32'hFFFF_FFFD, 64'h0000_0000_0000_0015, "mul -7x-3");
    set_case(3, `MUL_FUNC3_MULH, 32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000,
             "mulh min squared");
    set_case(4, `MUL_FUNC3_MULH, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'h0000_0000_0000_0001,
             "mulh -1x-1");
    set_case(5, `MUL_FUNC3_MUL, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 64'h3FFF_FFFF_0000_0001,
             "mul max squared");
    set_case(6, `MUL_FUNC3_MULH, 32'h8000_0000, 32'h7FFF_FFFF, 64'hC000_0000_8000_0000,
             "mulh min x max");
    set_case(7, `MUL_FUNC3_MUL, 32'h0000_0000, 32'hFFFF_FFFF, 64'h0000_0000_0000_0000, "mul 0x-1");
    set_case(8, `MUL_FUNC3_MUL, 32'h0001_0000, 32'hFFFF_0000, 64'hFFFF_FFFF_0000_0000,
             "mul 2^16 x -2^16");
    // signed x unsigned
    set_case(9, `MUL_FUNC3_MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'hFFFF_FFFF_0000_0001,
             "mulhsu -1 x ffffffff");
    set_case(10, `MUL_FUNC3_MULHSU, 32'h8000_0000, 32'hFFFF_FFFF, 64'h8000_0000_8000_0000,
             "mulhsu min x ffffffff");
    set_case(11, `MUL_FUNC3_MULHSU, 32'h0000_0005, 32'h8000_0000, 64'h0000_0002_8000_0000,
             "mulhsu 5 x 80000000");
    set_case(12, `MUL_FUNC3_MULHSU, 32'h7FFF_FFFF, 32'h8000_0000, 64'h3FFF_FFFF_8000_0000,
             "mulhsu max x 80000000");
    // unsigned x unsigned
    set_case(13, `MUL_FUNC3_MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'hFFFF_FFFE_0000_0001,
             "mulhu ffffffff squared");
    set_case(14, `MUL_FUNC3_MULHU, 32'h8000_0000, 32'h0000_0002, 64'h0000_0001_0000_0000,
             "mulhu 80000000 x 2");
    set_case(15, `MUL_FUNC3_MULHU, 32'hFFFF_FFFF, 32'h0000_0000, 64'h0000_0000_0000_0000,
             "mulhu ffffffff x 0");
    // unknown codes act like mul
    set_case(16, 3'b100, 32'hFFFF_FFFE, 32'h0000_0003, 64'hFFFF_FFFF_FFFF_FFFA, "code 100 -2x3");
    set_case(17, 3'b111, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'h0000_0000_0000_0001, "code 111 -1x-1");
endtask

//--- verification/int_mul_tb.sv
`include "mul_defines.svh"

module int_mul_tb import mul_pkg::*; ();

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 4;
    localparam int RAND_OPS     = 200;

    logic    clk;
    logic    arst_n_i;
    logic    mul_val_i;
    data_t   op1_i;
    data_t   op2_i;
    func3_t  func3_i;
    rob_id_t robid_i;
    logic    mul_val_o;
    prod_t   mul_result_o;
    rob_id_t robid_o;

    `include "int_mul_tb_cases.svh"

    // reset idle, each directed case, random phase
    localparam int NUM_TESTS = NUM_CASES + 2;
    // idle cycles never come twice in a row, so the random phase is at most 2 * RAND_OPS
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + NUM_CASES + 2 * RAND_OPS + 20;

    int seed = 51489;
    int cycle_cnt = 0;
    int error_count = 0;
    int check_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_errs [NUM_TESTS];
    string test_name [NUM_TESTS];

    // expected output per issue cycle, idle cycles included
    logic    exp_val_q [$];
    prod_t   exp_res_q [$];
    rob_id_t exp_tag_q [$];
    int      exp_issue_q [$];
    int      exp_test_q [$];

    int_mul dut0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .mul_val_i    (mul_val_i),
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .func3_i      (func3_i),
        .robid_i      (robid_i),
        .mul_val_o    (mul_val_o),
        .mul_result_o (mul_result_o),
        .robid_o      (robid_o)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    ////////////////////
    // reference model
    ////////////////////

    function automatic prod_t ref_product(input func3_t f, input data_t a, input data_t b);
        logic  sign_a;
        logic  sign_b;
        prod_t ext_a;
        prod_t ext_b;
        sign_a = (f != `MUL_FUNC3_MULHU);
        sign_b = (f != `MUL_FUNC3_MULHU) && (f != `MUL_FUNC3_MULHSU);
        ext_a  = sign_a ? {{`MUL_DATA_LEN{a[`MUL_DATA_LEN-1]}}, a} : {{`MUL_DATA_LEN{1'b0}}, a};
        ext_b  = sign_b ? {{`MUL_DATA_LEN{b[`MUL_DATA_LEN-1]}}, b} : {{`MUL_DATA_LEN{1'b0}}, b};
        // low 64 bits of the product
        return ext_a * ext_b;
    endfunction

    ////////////////////
    // drive
    ////////////////////

    task automatic push_expect(input logic v, input prod_t res, input rob_id_t tag, input int test);
        exp_val_q.push_back(v);
        exp_res_q.push_back(res);
        exp_tag_q.push_back(tag);
        exp_issue_q.push_back(cycle_cnt);
        exp_test_q.push_back(test);
    endtask

    task automatic issue_op(
        input func3_t  f,
        input data_t   a,
        input data_t   b,
        input rob_id_t tag,
        input prod_t   expected,
        input int      test
    );
        @(posedge clk);
        mul_val_i <= 1'b1;
        op1_i     <= a;
        op2_i     <= b;
        func3_i   <= f;
        robid_i   <= tag;
        push_expect(1'b1, expected, tag, test);
    endtask

    task automatic issue_idle(input int test);
        @(posedge clk);
        mul_val_i <= 1'b0;
        push_expect(1'b0, '0, '0, test);
    endtask

    ////////////////////
    // check
    ////////////////////

    task automatic check_value(input prod_t actual, input prod_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at time %0t: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic report_test(input int test);
        tests_run++;
        if (test_errs[test] == 0) begin
            $display("test %0d (%s): ok", test, test_name[test]);
        end else begin
            tests_failed++;
            $display("test %0d (%s): %0d mismatches", test, test_name[test], test_errs[test]);
        end
    endtask

    task automatic check_next_result();
        logic    exp_val;
        prod_t   exp_res;
        rob_id_t exp_tag;
        int      issue;
        int      test;
        int      errs_before;
        exp_val     = exp_val_q.pop_front();
        exp_res     = exp_res_q.pop_front();
        exp_tag     = exp_tag_q.pop_front();
        issue       = exp_issue_q.pop_front();
        test        = exp_test_q.pop_front();
        errs_before = error_count;
        check_value(mul_val_o, exp_val, $sformatf("valid strobe of cycle %0d", issue));
        if (exp_val) begin
            check_value(mul_result_o, exp_res, $sformatf("product of %s", test_name[test]));
            check_value(robid_o, exp_tag, $sformatf("tag of %s", test_name[test]));
        end
        test_errs[test] += error_count - errs_before;
        if (exp_test_q.size() == 0 || exp_test_q[0] != test) begin
            report_test(test);
        end
    endtask

    // result of the op issued at cycle n is stable after the following edge
    always @(negedge clk) begin
        if (exp_issue_q.size() > 0 && exp_issue_q[0] + 2 == cycle_cnt) begin
            check_next_result();
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        func3_t  f;
        data_t   a;
        data_t   b;
        rob_id_t tag;
        int      n_ops;
        logic    prev_idle;
        int      errs_before;

        arst_n_i  <= 1'b0;
        // strobe held high so only the reset keeps the output low
        mul_val_i <= 1'b1;
        op1_i     <= '0;
        op2_i     <= '0;
        func3_i   <= '0;
        robid_i   <= '0;

        load_cases();
        test_name[0] = "reset idle";
        for (int i = 0; i < NUM_CASES; i++) begin
            test_name[i + 1] = case_name[i];
        end
        test_name[NUM_TESTS - 1] = "random";
        for (int i = 0; i < NUM_TESTS; i++) begin
            test_errs[i] = 0;
        end

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        errs_before = error_count;
        check_value(mul_val_o, 1'b0, "valid strobe under reset");
        test_errs[0] += error_count - errs_before;
        @(posedge clk);
        arst_n_i  <= 1'b1;
        mul_val_i <= 1'b0;

        // strobe must stay low with no input
        repeat (IDLE_CYCLES) issue_idle(0);

        // tags alternate between the low and high end, 0 and 63 included
        for (int i = 0; i < NUM_CASES; i++) begin
            tag = (i % 2 == 0) ? i : 64 - i;
            issue_op(case_func3[i], case_op1[i], case_op2[i], tag, case_exp[i], i + 1);
        end

        n_ops     = 0;
        prev_idle = 1'b1;
        while (n_ops < RAND_OPS) begin
            if (!prev_idle && (($random(seed) & 7) == 0)) begin
                issue_idle(NUM_TESTS - 1);
                prev_idle = 1'b1;
            end else begin
                a   = $random(seed);
                b   = $random(seed);
                f   = $random(seed);
                tag = $random(seed);
                issue_op(f, a, b, tag, ref_product(f, a, b), NUM_TESTS - 1);
                prev_idle = 1'b0;
                n_ops++;
            end
        end
        issue_idle(NUM_TESTS - 1);

        while (exp_issue_q.size() != 0) @(posedge clk);

        if (tests_run != NUM_TESTS) begin
            error_count++;
            $display("only %0d of %0d tests completed", tests_run, NUM_TESTS);
        end
        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    ////////////////////
    // watchdog
    ////////////////////

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("watchdog expired after %0d cycles, results stopped arriving", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+source
+incdir+verification
source/mul_pkg.sv
source/mul_pp_gen.sv
source/compressor_4to2.sv
source/compressor_stage.sv
source/int_mul.sv
verification/int_mul_tb.sv
